//--- design/mem_cfg_pkg.sv
// --------------------------------------------------
// Memory map of the core test memory
// Region select bit, boot ROM layout and RAM depth
// --------------------------------------------------

`default_nettype none

package mem_cfg_pkg;

    // --------------------------------------------------
    // Region decode
    // --------------------------------------------------
    // Byte address bit that steers an access to the RAM when set
    localparam int unsigned REGION_BIT = 31;

    // --------------------------------------------------
    // Boot ROM
    // --------------------------------------------------
    // Words past this count read as zero
    localparam int unsigned ROM_WORDS = 32;
    // Upper half of every ROM word, word number added on top
    localparam logic [31:0] ROM_TAG = 32'hB007_0000;

    // --------------------------------------------------
    // RAM
    // --------------------------------------------------
    // Word address width, 1024 words of 64 bits by default
    localparam int unsigned RAM_AW_DEFAULT = 10;

endpackage : mem_cfg_pkg

`default_nettype wire

//--- design/core_bus_pkg.sv
// --------------------------------------------------
// Port-side types of the fetch and data interfaces
// --------------------------------------------------

`default_nettype none

package core_bus_pkg;

    // Full byte address as seen by the core
    typedef logic [63:0] addr_t;

    // One memory word
    typedef logic [63:0] data_t;

    // One enable per byte of a word
    typedef logic [7:0] be_t;

    // Byte address bits 11..0, sent with the data request
    typedef logic [11:0] index_t;

    // Byte address bits 55..12, sent one cycle later
    typedef logic [43:0] tag_t;

    // First stage of the data port
    // IDLE      nothing held, new request accepted
    // WAIT_TAG  request held, tag expected
    typedef enum logic {
        IDLE,
        WAIT_TAG
    } dstage_e;

endpackage : core_bus_pkg

`default_nettype wire

//--- design/boot_rom.sv
// --------------------------------------------------
// Boot ROM, combinational
// Word k holds ROM_TAG+k on top and its inverse below
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module boot_rom (
    input  core_bus_pkg::addr_t addr_i,
    output core_bus_pkg::data_t data_o
);
    import mem_cfg_pkg::*;

    // Word number from the byte address
    logic [60:0] word_idx;
    // Upper half of the addressed word
    logic [31:0] upper;

    assign word_idx = addr_i[63:3];
    assign upper    = ROM_TAG + 32'(word_idx);

    always_comb begin
        if (word_idx < 61'(ROM_WORDS)) begin
            data_o = {upper, ~upper};
        end else begin
            // Unpopulated part of the ROM
            data_o = '0;
        end
    end

endmodule : boot_rom

`default_nettype wire

//--- design/dp_ram.sv
// --------------------------------------------------
// Dual-port RAM, 64-bit words
// Port A read only, port B read/write with byte enables
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module dp_ram #(
    parameter int unsigned RAM_AW = mem_cfg_pkg::RAM_AW_DEFAULT
) (
    input  logic                clk_i,
    // Port A, fetch side
    input  logic                en_a_i,
    input  logic [RAM_AW-1:0]   addr_a_i,
    output core_bus_pkg::data_t rdata_a_o,
    // Port B, data side
    input  logic                en_b_i,
    input  logic                we_b_i,
    input  core_bus_pkg::be_t   be_b_i,
    input  logic [RAM_AW-1:0]   addr_b_i,
    input  core_bus_pkg::data_t wdata_b_i,
    output core_bus_pkg::data_t rdata_b_o
);
    import core_bus_pkg::*;

    localparam int unsigned DEPTH = 2 ** RAM_AW;

    // Storage array
    data_t mem_q [DEPTH];

    // --------------------------------------------------
    // Port A
    // --------------------------------------------------
    // Word appears the cycle after the enable
    always_ff @(posedge clk_i) begin
        if (en_a_i) begin
            rdata_a_o <= mem_q[addr_a_i];
        end
    end

    // --------------------------------------------------
    // Port B
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (en_b_i) begin
            if (we_b_i) begin
                // Merge only the enabled bytes
                for (int i = 0; i < 8; i++) begin
                    if (be_b_i[i]) begin
                        mem_q[addr_b_i][i*8 +: 8] <= wdata_b_i[i*8 +: 8];
                    end
                end
            end
            // Read returns the old word on a write
            rdata_b_o <= mem_q[addr_b_i];
        end
    end

endmodule : dp_ram

`default_nettype wire

//--- design/fetch_port.sv
// --------------------------------------------------
// Instruction fetch port
// Grants at once, answers one cycle later from RAM or ROM
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fetch_port #(
    parameter int unsigned RAM_AW = mem_cfg_pkg::RAM_AW_DEFAULT
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    // Requester side
    input  core_bus_pkg::addr_t addr_i,
    input  logic                req_i,
    output logic                gnt_o,
    output logic                rvalid_o,
    output core_bus_pkg::data_t rdata_o,
    // RAM port A
    output logic                ram_en_o,
    output logic [RAM_AW-1:0]   ram_addr_o,
    input  core_bus_pkg::data_t ram_rdata_i,
    // Boot ROM
    output core_bus_pkg::addr_t rom_addr_o,
    input  core_bus_pkg::data_t rom_data_i
);
    import mem_cfg_pkg::*;
    import core_bus_pkg::*;

    logic  req_q;
    // Byte address of the request being answered
    addr_t addr_q;

    // Every request is accepted
    assign gnt_o = req_i;

    // RAM read starts in the request cycle
    assign ram_en_o   = req_i;
    assign ram_addr_o = addr_i[RAM_AW+2:3];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            addr_q <= addr_i;
        end
    end

    // Response cycle, region of the registered address picks the source
    assign rom_addr_o = addr_q;
    assign rvalid_o   = req_q;
    assign rdata_o    = addr_q[REGION_BIT] ? ram_rdata_i : rom_data_i;

endmodule : fetch_port

`default_nettype wire

//--- design/data_port.sv
// --------------------------------------------------
// Data port, two-stage pipeline
// Index with the request, tag one cycle later, kill drops
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module data_port #(
    parameter int unsigned RAM_AW = mem_cfg_pkg::RAM_AW_DEFAULT
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // Requester side
    input  core_bus_pkg::index_t index_i,
    input  core_bus_pkg::tag_t   tag_i,
    input  core_bus_pkg::data_t  wdata_i,
    input  logic                 req_i,
    input  logic                 we_i,
    input  core_bus_pkg::be_t    be_i,
    input  logic                 kill_i,
    input  logic                 tag_valid_i,
    output logic                 gnt_o,
    output logic                 rvalid_o,
    output core_bus_pkg::data_t  rdata_o,
    // RAM port B
    output logic                 ram_en_o,
    output logic                 ram_we_o,
    output core_bus_pkg::be_t    ram_be_o,
    output logic [RAM_AW-1:0]    ram_addr_o,
    output core_bus_pkg::data_t  ram_wdata_o,
    input  core_bus_pkg::data_t  ram_rdata_i,
    // Boot ROM
    output core_bus_pkg::addr_t  rom_addr_o,
    input  core_bus_pkg::data_t  rom_data_i
);
    import mem_cfg_pkg::*;
    import core_bus_pkg::*;

    // --------------------------------------------------
    // Stage one, request held until its tag arrives
    // --------------------------------------------------
    dstage_e stage_q, stage_d;
    index_t  index_q;
    logic    we_q;
    be_t     be_q;
    data_t   wdata_q;

    logic    access;
    addr_t   full_addr;

    // Stage frees up this cycle if idle or its tag or kill is here
    assign gnt_o  = req_i && ((stage_q == IDLE) || tag_valid_i || kill_i);
    // Kill wins over a tag in the same cycle
    assign access = (stage_q == WAIT_TAG) && tag_valid_i && !kill_i;

    // Tag on top of the held index
    assign full_addr = {8'h00, tag_i, index_q};

    always_comb begin
        stage_d = stage_q;
        if (gnt_o) begin
            stage_d = WAIT_TAG;
        end else if ((stage_q == WAIT_TAG) && (tag_valid_i || kill_i)) begin
            stage_d = IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stage_q <= IDLE;
        end else begin
            stage_q <= stage_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (gnt_o) begin
            index_q <= index_i;
            we_q    <= we_i;
            be_q    <= be_i;
            wdata_q <= wdata_i;
        end
    end

    // RAM access, writes outside the RAM region are dropped
    assign ram_en_o    = access;
    assign ram_we_o    = we_q && full_addr[REGION_BIT];
    assign ram_be_o    = be_q;
    assign ram_addr_o  = full_addr[RAM_AW+2:3];
    assign ram_wdata_o = wdata_q;

    // --------------------------------------------------
    // Stage two, response
    // --------------------------------------------------
    logic  rvalid_q;
    logic  region_q;
    addr_t addr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= access;
        end
    end

    always_ff @(posedge clk_i) begin
        if (access) begin
            region_q <= full_addr[REGION_BIT];
            addr_q   <= full_addr;
        end
    end

    assign rom_addr_o = addr_q;
    assign rvalid_o   = rvalid_q;
    assign rdata_o    = region_q ? ram_rdata_i : rom_data_i;

endmodule : data_port

`default_nettype wire

//--- design/core_mem.sv
// --------------------------------------------------
// Core memory model, top level
// Fetch and data ports over one dual-port RAM, two ROMs
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_mem #(
    parameter int unsigned RAM_AW = mem_cfg_pkg::RAM_AW_DEFAULT
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // Instruction fetch
    input  core_bus_pkg::addr_t  instr_addr_i,
    input  logic                 instr_req_i,
    output logic                 instr_gnt_o,
    output logic                 instr_rvalid_o,
    output core_bus_pkg::data_t  instr_rdata_o,
    // Data access
    input  core_bus_pkg::index_t data_index_i,
    input  core_bus_pkg::tag_t   data_tag_i,
    input  core_bus_pkg::data_t  data_wdata_i,
    input  logic                 data_req_i,
    input  logic                 data_we_i,
    input  core_bus_pkg::be_t    data_be_i,
    input  logic                 data_kill_i,
    input  logic                 data_tag_valid_i,
    output logic                 data_gnt_o,
    output logic                 data_rvalid_o,
    output core_bus_pkg::data_t  data_rdata_o
);
    import core_bus_pkg::*;

    // --------------------------------------------------
    // Fetch side wires
    // --------------------------------------------------
    logic              fetch_ram_en;
    logic [RAM_AW-1:0] fetch_ram_addr;
    data_t             fetch_ram_rdata;
    addr_t             fetch_rom_addr;
    data_t             fetch_rom_data;

    // --------------------------------------------------
    // Data side wires
    // --------------------------------------------------
    logic              data_ram_en;
    logic              data_ram_we;
    be_t               data_ram_be;
    logic [RAM_AW-1:0] data_ram_addr;
    data_t             data_ram_wdata;
    data_t             data_ram_rdata;
    addr_t             data_rom_addr;
    data_t             data_rom_data;

    fetch_port #(
        .RAM_AW      ( RAM_AW          )
    ) i_fetch_port (
        .clk_i       ( clk_i           ),
        .rst_ni      ( rst_ni          ),
        .addr_i      ( instr_addr_i    ),
        .req_i       ( instr_req_i     ),
        .gnt_o       ( instr_gnt_o     ),
        .rvalid_o    ( instr_rvalid_o  ),
        .rdata_o     ( instr_rdata_o   ),
        .ram_en_o    ( fetch_ram_en    ),
        .ram_addr_o  ( fetch_ram_addr  ),
        .ram_rdata_i ( fetch_ram_rdata ),
        .rom_addr_o  ( fetch_rom_addr  ),
        .rom_data_i  ( fetch_rom_data  )
    );

    data_port #(
        .RAM_AW      ( RAM_AW           )
    ) i_data_port (
        .clk_i       ( clk_i            ),
        .rst_ni      ( rst_ni           ),
        .index_i     ( data_index_i     ),
        .tag_i       ( data_tag_i       ),
        .wdata_i     ( data_wdata_i     ),
        .req_i       ( data_req_i       ),
        .we_i        ( data_we_i        ),
        .be_i        ( data_be_i        ),
        .kill_i      ( data_kill_i      ),
        .tag_valid_i ( data_tag_valid_i ),
        .gnt_o       ( data_gnt_o       ),
        .rvalid_o    ( data_rvalid_o    ),
        .rdata_o     ( data_rdata_o     ),
        .ram_en_o    ( data_ram_en      ),
        .ram_we_o    ( data_ram_we      ),
        .ram_be_o    ( data_ram_be      ),
        .ram_addr_o  ( data_ram_addr    ),
        .ram_wdata_o ( data_ram_wdata   ),
        .ram_rdata_i ( data_ram_rdata   ),
        .rom_addr_o  ( data_rom_addr    ),
        .rom_data_i  ( data_rom_data    )
    );

    // Port A serves fetches, port B serves data
    dp_ram #(
        .RAM_AW    ( RAM_AW          )
    ) i_dp_ram (
        .clk_i     ( clk_i           ),
        .en_a_i    ( fetch_ram_en    ),
        .addr_a_i  ( fetch_ram_addr  ),
        .rdata_a_o ( fetch_ram_rdata ),
        .en_b_i    ( data_ram_en     ),
        .we_b_i    ( data_ram_we     ),
        .be_b_i    ( data_ram_be     ),
        .addr_b_i  ( data_ram_addr   ),
        .wdata_b_i ( data_ram_wdata  ),
        .rdata_b_o ( data_ram_rdata  )
    );

    // One ROM copy per port
    boot_rom i_fetch_rom (
        .addr_i ( fetch_rom_addr ),
        .data_o ( fetch_rom_data )
    );

    boot_rom i_data_rom (
        .addr_i ( data_rom_addr ),
        .data_o ( data_rom_data )
    );

endmodule : core_mem

`default_nettype wire

//--- tests/core_mem_properties.sv
// --------------------------------------------------
// Handshake assertions for the core memory
// Bound into the top level, watches both ports
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_mem_properties (
    input logic clk_i,
    input logic rst_ni,
    input logic instr_req_i,
    input logic instr_rvalid_i,
    input logic data_gnt_i,
    input logic data_tag_valid_i,
    input logic data_kill_i,
    input logic data_rvalid_i
);
    // Granted request still expecting its tag
    logic waiting_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            waiting_q <= 1'b0;
        end else if (data_gnt_i) begin
            waiting_q <= 1'b1;
        end else if (data_tag_valid_i || data_kill_i) begin
            waiting_q <= 1'b0;
        end
    end

    // Fetch answer exactly one cycle after each request
    fetch_rvalid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
        1'b1 |=> (instr_rvalid_i == $past(instr_req_i)))
        else $error("fetch rvalid out of step with the request");

    // No new grant while the held request lacks its tag
    gnt_while_waiting_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (waiting_q && !data_tag_valid_i && !data_kill_i) |-> !data_gnt_i)
        else $error("data grant given while a tag is outstanding");

    // Response only after a granted request got its tag
    rvalid_after_gnt_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_rvalid_i |-> $past(waiting_q && data_tag_valid_i && !data_kill_i))
        else $error("data rvalid without an earlier grant");

endmodule : core_mem_properties

bind core_mem core_mem_properties i_props (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .instr_req_i      ( instr_req_i      ),
    .instr_rvalid_i   ( instr_rvalid_o   ),
    .data_gnt_i       ( data_gnt_o       ),
    .data_tag_valid_i ( data_tag_valid_i ),
    .data_kill_i      ( data_kill_i      ),
    .data_rvalid_i    ( data_rvalid_o    )
);

`default_nettype wire

//--- tests/core_mem_tb.sv
// --------------------------------------------------
// Testbench for the core memory
// Random fetch and data traffic against a shadow model
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_mem_tb;
    import mem_cfg_pkg::*;
    import core_bus_pkg::*;

    localparam int unsigned RAM_AW = RAM_AW_DEFAULT;
    localparam int WAIT_LIMIT = 100;

    typedef logic [RAM_AW-1:0] widx_t;

    logic   clk, rst_n;
    addr_t  instr_addr;
    logic   instr_req, instr_gnt, instr_rvalid;
    data_t  instr_rdata;
    index_t data_index;
    tag_t   data_tag;
    data_t  data_wdata, data_rdata;
    be_t    data_be;
    logic   data_req, data_we, data_kill, data_tag_valid;
    logic   data_gnt, data_rvalid;

    int seed = 29150;

    // Shadow of the RAM and words known to hold data
    data_t shadow [2**RAM_AW];
    widx_t written_q [$];
    // Expected responses in issue order
    data_t instr_exp_q [$];
    data_t data_exp_q [$];
    logic  data_chk_q [$];

    core_mem #(
        .RAM_AW           ( RAM_AW         )
    ) dut_i (
        .clk_i            ( clk            ),
        .rst_ni           ( rst_n          ),
        .instr_addr_i     ( instr_addr     ),
        .instr_req_i      ( instr_req      ),
        .instr_gnt_o      ( instr_gnt      ),
        .instr_rvalid_o   ( instr_rvalid   ),
        .instr_rdata_o    ( instr_rdata    ),
        .data_index_i     ( data_index     ),
        .data_tag_i       ( data_tag       ),
        .data_wdata_i     ( data_wdata     ),
        .data_req_i       ( data_req       ),
        .data_we_i        ( data_we        ),
        .data_be_i        ( data_be        ),
        .data_kill_i      ( data_kill      ),
        .data_tag_valid_i ( data_tag_valid ),
        .data_gnt_o       ( data_gnt       ),
        .data_rvalid_o    ( data_rvalid    ),
        .data_rdata_o     ( data_rdata     )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    // Boot ROM word for a byte address
    function automatic data_t rom_word(addr_t addr);
        logic [31:0] up;
        // Word number is the byte address over the 8-byte word size
        up = ROM_TAG + 32'(addr >> 3);
        if ((addr >> 3) < 64'(ROM_WORDS)) begin
            return {up, up ^ 32'hFFFF_FFFF};
        end else begin
            return '0;
        end
    endfunction

    // RAM region answers from the shadow, the rest from the ROM rule
    function automatic data_t expect_read(addr_t addr);
        if (addr[REGION_BIT]) begin
            return shadow[addr[RAM_AW+2:3]];
        end else begin
            return rom_word(addr);
        end
    endfunction

    // Old word with the enabled bytes replaced
    function automatic data_t merge_bytes(data_t old, data_t wdata, be_t be);
        for (int i = 0; i < 8; i++) begin
            if (be[i]) begin
                old[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return old;
    endfunction

    // Byte address of a RAM word
    function automatic addr_t ram_addr(widx_t w);
        addr_t a;
        a = '0;
        a[REGION_BIT] = 1'b1;
        a[RAM_AW+2:3] = w;
        return a;
    endfunction

    function automatic int rand_below(int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    // --------------------------------------------------
    // Error reporting and compare tasks
    // --------------------------------------------------
    task automatic stop_run(string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_instr(data_t got, data_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED at %0t ns: instr_rdata %h, expected %h",
                               $time, got, exp));
        end
    endtask

    task automatic check_data(data_t got, data_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED at %0t ns: data_rdata %h, expected %h",
                               $time, got, exp));
        end
    endtask

    // Responses compared in order and sampled mid-cycle
    always @(negedge clk) begin
        data_t exp_i;
        data_t exp_d;
        logic  chk;
        if (rst_n) begin
            if (instr_rvalid) begin
                if (instr_exp_q.size() == 0) begin
                    stop_run("Fetch response arrived with no fetch outstanding");
                end else begin
                    exp_i = instr_exp_q.pop_front();
                    check_instr(instr_rdata, exp_i);
                end
            end
            if (data_rvalid) begin
                if (data_exp_q.size() == 0) begin
                    stop_run("Data response arrived with no access outstanding");
                end else begin
                    exp_d = data_exp_q.pop_front();
                    // Write responses carry no data worth comparing
                    chk   = data_chk_q.pop_front();
                    if (chk) begin
                        check_data(data_rdata, exp_d);
                    end
                end
            end
        end
    end

    // --------------------------------------------------
    // Stimulus tasks entered right after a rising edge
    // --------------------------------------------------
    // One fetch with the request kept high for a back-to-back follower
    task automatic fetch_one(addr_t addr, logic last);
        instr_req  <= 1'b1;
        instr_addr <= addr;
        instr_exp_q.push_back(expect_read(addr));
        @(negedge clk);
        if (!instr_gnt) begin
            stop_run("Fetch request was not granted in its own cycle");
        end
        @(posedge clk);
        if (last) begin
            instr_req <= 1'b0;
        end
    endtask

    // First half of a data access, index with the request
    task automatic drive_request(addr_t addr, logic we, be_t be, data_t wdata);
        data_req   <= 1'b1;
        data_index <= addr[11:0];
        data_we    <= we;
        data_be    <= be;
        data_wdata <= wdata;
    endtask

    // Returns right after the rising edge that takes the grant
    task automatic wait_grant();
        int n;
        n = 0;
        @(negedge clk);
        while (!data_gnt) begin
            if (n == WAIT_LIMIT) begin
                stop_run("Data request was never granted, data_gnt_o stuck low");
            end
            @(negedge clk);
            n++;
        end
        @(posedge clk);
    endtask

    // Tag held back while the grant must stay low
    task automatic hold_tag(int delay);
        for (int n = 0; n < delay; n++) begin
            @(negedge clk);
            if (data_gnt) begin
                stop_run("data_gnt_o rose while a tag was still outstanding");
            end
            @(posedge clk);
        end
    endtask

    task automatic data_access(addr_t addr, logic we, be_t be, data_t wdata,
                               logic kill, int delay);
        widx_t idx;
        idx = addr[RAM_AW+2:3];
        drive_request(addr, we, be, wdata);
        wait_grant();
        data_req <= 1'b0;
        hold_tag(delay);
        data_tag <= addr[55:12];
        if (kill) begin
            data_kill <= 1'b1;
        end else begin
            data_tag_valid <= 1'b1;
            // Only the RAM region takes writes
            if (we && addr[REGION_BIT]) begin
                shadow[idx] = merge_bytes(shadow[idx], wdata, be);
            end
            data_exp_q.push_back(we ? data_t'('0) : expect_read(addr));
            data_chk_q.push_back(!we);
        end
        @(posedge clk);
        data_tag_valid <= 1'b0;
        data_kill      <= 1'b0;
    endtask

    // Second read queued behind a first one whose tag is late
    task automatic stalled_pair(addr_t first, addr_t second, int delay);
        drive_request(first, 1'b0, '0, '0);
        wait_grant();
        drive_request(second, 1'b0, '0, '0);
        hold_tag(delay);
        data_tag       <= first[55:12];
        data_tag_valid <= 1'b1;
        data_exp_q.push_back(expect_read(first));
        data_chk_q.push_back(1'b1);
        // Tag of the first frees the stage for the second
        @(negedge clk);
        if (!data_gnt) begin
            stop_run("Queued request was not granted when the tag arrived");
        end
        @(posedge clk);
        data_req <= 1'b0;
        data_tag <= second[55:12];
        data_exp_q.push_back(expect_read(second));
        data_chk_q.push_back(1'b1);
        @(posedge clk);
        data_tag_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (instr_exp_q.size() != 0 || data_exp_q.size() != 0) begin
            if (n == WAIT_LIMIT) begin
                stop_run("Responses still missing, rvalid never came back");
            end
            @(posedge clk);
            n++;
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int    r;
        addr_t a;
        addr_t b;
        widx_t w;
        data_t d;
        instr_addr     = '0;
        instr_req      = 1'b0;
        data_index     = '0;
        data_tag       = '0;
        data_wdata     = '0;
        data_be        = '0;
        data_req       = 1'b0;
        data_we        = 1'b0;
        data_kill      = 1'b0;
        data_tag_valid = 1'b0;
        rst_n          = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // ROM fetches with some far past the populated words
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            a = '0;
            if (i % 4 == 0) begin
                a[29:0] = r[29:0];
            end else begin
                a[8:0] = r[8:0];
            end
            fetch_one(a, i == 39);
        end

        // Full-word writes then reads on both ports
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            w = r[RAM_AW-1:0];
            d = {$random(seed), $random(seed)};
            written_q.push_back(w);
            data_access(ram_addr(w), 1'b1, 8'hFF, d, 1'b0, 0);
        end
        foreach (written_q[i]) begin
            data_access(ram_addr(written_q[i]), 1'b0, '0, '0, 1'b0, 0);
            fetch_one(ram_addr(written_q[i]), 1'b1);
        end

        // Partial writes merge into known words
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            a = ram_addr(written_q[rand_below(written_q.size())]);
            d = {$random(seed), $random(seed)};
            data_access(a, 1'b1, r[7:0], d, 1'b0, 0);
            data_access(a, 1'b0, '0, '0, 1'b0, 0);
        end

        // Killed writes leave the word unchanged
        for (int i = 0; i < 4; i++) begin
            a = ram_addr(written_q[rand_below(written_q.size())]);
            d = {$random(seed), $random(seed)};
            data_access(a, 1'b1, 8'hFF, d, 1'b1, 0);
            data_access(a, 1'b0, '0, '0, 1'b0, 0);
        end

        // Late tags with a second request waiting
        for (int i = 0; i < 8; i++) begin
            a = ram_addr(written_q[rand_below(written_q.size())]);
            b = '0;
            b[7:3] = 5'(rand_below(32));
            stalled_pair(a, b, 1 + rand_below(6));
            data_access(b, 1'b0, '0, '0, 1'b0, rand_below(5));
        end

        // Writes into the ROM region are ignored
        for (int i = 0; i < 6; i++) begin
            a = '0;
            a[7:3] = 5'(rand_below(32));
            w = a[RAM_AW+2:3];
            // RAM word at the same index must keep its contents
            d = {$random(seed), $random(seed)};
            data_access(ram_addr(w), 1'b1, 8'hFF, d, 1'b0, 0);
            d = {$random(seed), $random(seed)};
            data_access(a, 1'b1, 8'hFF, d, 1'b0, 0);
            data_access(a, 1'b0, '0, '0, 1'b0, 0);
            data_access(ram_addr(w), 1'b0, '0, '0, 1'b0, 0);
            fetch_one(a, 1'b1);
        end

        wait_drain();
        repeat (5) @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule : core_mem_tb

`default_nettype wire

//--- src.f
design/mem_cfg_pkg.sv
design/core_bus_pkg.sv
design/boot_rom.sv
design/dp_ram.sv
design/fetch_port.sv
design/data_port.sv
design/core_mem.sv
tests/core_mem_properties.sv
tests/core_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core memory testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module core_mem_tb -f src.f -o core_mem_sim > sim.log 2>&1 \
    && ./obj_dir/core_mem_sim >> sim.log 2>&1 \
    || echo "Something failed" >> sim.log
if grep -q "Something failed" sim.log; then
    echo "FAIL, see sim.log"
    exit 1
fi
echo "PASS"
exit 0
